// ==== rv_pkg.sv ====
// Shared types and encodings for the RV32I subset core.
package rv_pkg;

  // Word widths used across the core.
  typedef logic [31:0] xlen_t;    // Register or data word.
  typedef logic [31:0] inst_t;    // Raw instruction word.
  typedef logic [4:0]  reg_idx_t; // Register index, x0..x31.
  typedef logic [31:0] pc_t;      // Instruction address.

  // Major opcodes, inst[6:0].
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 values shared by OP and OP-IMM.
  localparam logic [2:0] F3_ADD = 3'b000; // Also sub, told apart by funct7.
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct7 for sub; add and the logic ops use all zeros.
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // The one SYSTEM encoding that is accepted.
  localparam inst_t INST_EBREAK = 32'h0010_0073;

  // Program counter reset value and step.
  localparam pc_t PC_RESET = 32'h8000_0000;
  localparam pc_t PC_STEP  = 32'd4;

  // ALU operations.
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5, // Signed compare, result is 0 or 1.
    ALU_PASS_B = 3'd6  // Operand 2 straight through, for lui.
  } alu_op_e;

endpackage

// ==== decode_if.sv ====
`timescale 1ns/1ps

// Decoded instruction bundle, decoder to execute unit.
interface decode_if import rv_pkg::*; ();

  reg_idx_t rd;        // Destination register.
  reg_idx_t rs1;       // Source register 1.
  reg_idx_t rs2;       // Source register 2.
  xlen_t    imm;       // Sign extended I or U immediate.
  alu_op_e  alu_op;    // Operation to apply.
  logic     use_imm;   // Operand 2 is imm, not rs2.
  logic     use_pc;    // Operand 1 is the pc, for auipc.
  logic     writes_rd; // Instruction has a register result.
  logic     is_ebreak; // Halt request.
  logic     illegal;   // Encoding outside the subset.

  // Decoder side.
  modport src (
    output rd, rs1, rs2, imm, alu_op,
    output use_imm, use_pc, writes_rd, is_ebreak, illegal
  );

  // Execute side.
  modport dst (
    input rd, rs1, rs2, imm, alu_op,
    input use_imm, use_pc, writes_rd, is_ebreak, illegal
  );

endinterface

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

// Combinational decoder for the supported RV32I subset.
module rv_decoder import rv_pkg::*; (
  input  inst_t inst,
  decode_if.src dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_u;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]}; // Sign extended 12 bits.
  assign imm_u = {inst[31:12], 12'b0};          // Upper 20 bits.

  // Register fields sit at fixed positions in every format.
  assign dec.rd  = inst[11:7];
  assign dec.rs1 = inst[19:15];
  assign dec.rs2 = inst[24:20];

  always_comb begin
    // Defaults describe an illegal instruction with no effect.
    dec.imm       = imm_i;
    dec.alu_op    = ALU_ADD;
    dec.use_imm   = 1'b0;
    dec.use_pc    = 1'b0;
    dec.writes_rd = 1'b0;
    dec.is_ebreak = 1'b0;
    dec.illegal   = 1'b1;

    case (opcode)
      OPC_LUI: begin
        dec.imm       = imm_u;
        dec.alu_op    = ALU_PASS_B;
        dec.use_imm   = 1'b1;
        dec.writes_rd = 1'b1;
        dec.illegal   = 1'b0;
      end
      OPC_AUIPC: begin
        dec.imm       = imm_u;
        dec.alu_op    = ALU_ADD;   // pc + imm.
        dec.use_imm   = 1'b1;
        dec.use_pc    = 1'b1;
        dec.writes_rd = 1'b1;
        dec.illegal   = 1'b0;
      end
      OPC_OP_IMM: begin
        dec.use_imm = 1'b1;
        case (funct3)
          F3_ADD:  dec.alu_op = ALU_ADD;
          F3_SLT:  dec.alu_op = ALU_SLT;
          F3_XOR:  dec.alu_op = ALU_XOR;
          F3_OR:   dec.alu_op = ALU_OR;
          F3_AND:  dec.alu_op = ALU_AND;
          default: dec.alu_op = ALU_ADD; // Shifts and sltiu fall here.
        endcase
        if (funct3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND}) begin
          dec.writes_rd = 1'b1;
          dec.illegal   = 1'b0;
        end
      end
      OPC_OP: begin
        if (funct7 == 7'b0) begin
          case (funct3)
            F3_ADD:  dec.alu_op = ALU_ADD;
            F3_SLT:  dec.alu_op = ALU_SLT;
            F3_XOR:  dec.alu_op = ALU_XOR;
            F3_OR:   dec.alu_op = ALU_OR;
            F3_AND:  dec.alu_op = ALU_AND;
            default: dec.alu_op = ALU_ADD;
          endcase
          if (funct3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND}) begin
            dec.writes_rd = 1'b1;
            dec.illegal   = 1'b0;
          end
        end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
          dec.alu_op    = ALU_SUB;
          dec.writes_rd = 1'b1;
          dec.illegal   = 1'b0;
        end
      end
      OPC_SYSTEM: begin
        // Only ebreak; ecall and CSR accesses stay illegal.
        if (inst == INST_EBREAK) begin
          dec.is_ebreak = 1'b1;
          dec.illegal   = 1'b0;
        end
      end
      default: ; // Keep the illegal defaults.
    endcase
  end

  // An illegal encoding must never reach the register file.
  always_comb begin
    assert (!(dec.illegal && dec.writes_rd))
      else $error("decoder flags illegal instruction %h as writing rd", inst);
  end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

// 32 x 32 register file, x0 reads as zero.
module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     wen,
  input  xlen_t    wdata,
  output xlen_t    rdata_1,
  output xlen_t    rdata_2
);

  xlen_t regs [1:31]; // No storage behind x0.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin // Writes to x0 are dropped.
      regs[rd] <= wdata;
    end
  end

  // Combinational reads, so a write shows up on the next cycle's read.
  always_comb begin
    if (rs1 == '0) begin
      rdata_1 = '0;
    end else begin
      rdata_1 = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rdata_2 = '0;
    end else begin
      rdata_2 = regs[rs2];
    end
  end

  // x0 stays zero on both ports, even right after a write aimed at it.
  a_x0_reads_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
      ((rs1 == '0) |-> (rdata_1 == '0)) and ((rs2 == '0) |-> (rdata_2 == '0))
  ) else $error("register file returned nonzero for x0");

endmodule

// ==== alu_exec.sv ====
`timescale 1ns/1ps

// Execute unit with operand select, ALU and write enable.
module alu_exec import rv_pkg::*; (
  decode_if.dst dec,
  input  xlen_t rdata_1,
  input  xlen_t rdata_2,
  input  pc_t   pc,
  input  logic  issue,
  output logic  wen,
  output xlen_t wdata
);

  xlen_t operand_1;
  xlen_t operand_2;
  xlen_t result;

  // auipc takes the pc in place of rs1.
  assign operand_1 = dec.use_pc ? pc : rdata_1;
  // Immediate forms take imm in place of rs2.
  assign operand_2 = dec.use_imm ? dec.imm : rdata_2;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    result = operand_1 + operand_2;
      ALU_SUB:    result = operand_1 - operand_2;
      ALU_AND:    result = operand_1 & operand_2;
      ALU_OR:     result = operand_1 | operand_2;
      ALU_XOR:    result = operand_1 ^ operand_2;
      ALU_SLT: begin
        // Signed compare zero extended to a word.
        result = {31'b0, $signed(operand_1) < $signed(operand_2)};
      end
      ALU_PASS_B: result = operand_2;                // lui.
      default:    result = '0;
    endcase
  end

  // Only an issued instruction with a real destination writes.
  assign wen   = issue && dec.writes_rd && (dec.rd != '0);
  assign wdata = result;

endmodule

// ==== retire_unit.sv ====
`timescale 1ns/1ps

// PC, halt state and the registered retire report.
module retire_unit import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     inst_valid,
  input  logic     is_ebreak,
  input  logic     illegal,
  input  logic     wen,
  input  reg_idx_t rd,
  input  xlen_t    wdata,
  output logic     issue,
  output pc_t      pc,
  output pc_t      next_pc,
  output logic     halted,
  output logic     retire_valid,
  output logic     retire_wen,
  output reg_idx_t retire_rd,
  output xlen_t    retire_data,
  output pc_t      retire_pc,
  output logic     illegal_seen
);

  // A strobe while halted is dropped.
  assign issue   = inst_valid && !halted;
  assign next_pc = pc + PC_STEP; // Every instruction steps by one word.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc           <= PC_RESET;
      halted       <= 1'b0;
      illegal_seen <= 1'b0;
      retire_valid <= 1'b0;
      retire_wen   <= 1'b0;
    end else begin
      retire_valid <= issue; // One cycle strobe after the issue cycle.
      retire_wen   <= wen;   // Already qualified by issue.
      if (issue) begin
        pc <= next_pc;
        if (is_ebreak) begin
          halted <= 1'b1;       // Held until reset.
        end
        if (illegal) begin
          illegal_seen <= 1'b1; // Sticky.
        end
      end
    end
  end

  // Report payload is only meaningful while retire_valid is high.
  always_ff @(posedge clk) begin
    if (issue) begin
      retire_rd   <= rd;
      retire_data <= wdata;
      retire_pc   <= pc;
    end
  end

  // A retire strobe follows an issue edge that stepped the pc it reports.
  a_retire_after_issue: assert property (
    @(posedge clk) disable iff (!arst_n)
      retire_valid |-> (pc == $past(pc) + PC_STEP) && (retire_pc == $past(pc))
  ) else $error("retire_valid without a preceding issue");

endmodule

// ==== core_top.sv ====
`timescale 1ns/1ps

// Single cycle RV32I subset core.
module core_top import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     inst_valid,
  input  inst_t    inst,
  output pc_t      pc,
  output pc_t      next_pc,
  output logic     retire_valid,
  output logic     retire_wen,
  output reg_idx_t retire_rd,
  output xlen_t    retire_data,
  output pc_t      retire_pc,
  output logic     halted,
  output logic     illegal_seen
);

  xlen_t rdata_1;
  xlen_t rdata_2;
  logic  wen;
  xlen_t wdata;
  logic  issue;

  decode_if dec_if ();

  rv_decoder rv_decoder_inst (
    .inst (inst),
    .dec  (dec_if.src)
  );

  reg_file reg_file_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1     (dec_if.rs1),
    .rs2     (dec_if.rs2),
    .rd      (dec_if.rd),
    .wen     (wen),
    .wdata   (wdata),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  alu_exec alu_exec_inst (
    .dec     (dec_if.dst),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2),
    .pc      (pc),
    .issue   (issue),
    .wen     (wen),
    .wdata   (wdata)
  );

  retire_unit retire_unit_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst_valid   (inst_valid),
    .is_ebreak    (dec_if.is_ebreak),
    .illegal      (dec_if.illegal),
    .wen          (wen),
    .rd           (dec_if.rd),
    .wdata        (wdata),
    .issue        (issue),
    .pc           (pc),
    .next_pc      (next_pc),
    .halted       (halted),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .retire_pc    (retire_pc),
    .illegal_seen (illegal_seen)
  );

endmodule

// ==== tb_core.sv ====
`timescale 1ns/1ps

// Directed testbench for the single cycle RV32I subset core.
module tb_core import rv_pkg::*; ();

  localparam int cycle_limit = 2000; // Far above the length of the full test run.

  logic     clk;
  logic     arst_n;
  logic     inst_valid;
  inst_t    inst;
  pc_t      pc;
  pc_t      next_pc;
  logic     retire_valid;
  logic     retire_wen;
  reg_idx_t retire_rd;
  xlen_t    retire_data;
  pc_t      retire_pc;
  logic     halted;
  logic     illegal_seen;

  logic [31:0] xreg [32]; // Shadow register file.
  logic [31:0] shadow_pc; // Shadow program counter.
  logic [31:0] rnd;
  logic [31:0] rnd2;
  integer      seed;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  core_top core_top_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .pc           (pc),
    .next_pc      (next_pc),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .retire_pc    (retire_pc),
    .halted       (halted),
    .illegal_seen (illegal_seen)
  );

  always #10 clk = ~clk; // 20 ns period.

  // Run limit in case a strobe or the clock gets stuck.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("checks: %0d  errors: %0d", checks, errors + 1);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Instruction encoders following the RV32I formats.
  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  // Expected result for the funct3 groups of OP and OP-IMM.
  function automatic logic [31:0] expect_alu(input logic [2:0] f3, input logic sub,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // Signed.
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [2:0] pick_f3(input logic [31:0] r);
    case (r % 32'd5)
      32'd0:   return F3_ADD;
      32'd1:   return F3_SLT;
      32'd2:   return F3_XOR;
      32'd3:   return F3_OR;
      default: return F3_AND;
    endcase
  endfunction

  // Issue one instruction and check its retire report against the shadow model.
  task automatic run_inst(input logic [31:0] word, input logic exp_wen,
                          input logic [4:0] exp_rd, input logic [31:0] exp_data);
    inst_valid = 1'b1;
    inst       = word;
    @(negedge clk);
    inst_valid = 1'b0; // A following call raises it again in this step.
    if (!retire_valid) begin
      $display("no retire strobe in the cycle after instruction %h at pc %h",
               word, shadow_pc);
      errors++;
    end else begin
      check("retire_pc", shadow_pc, retire_pc);
      check("retire_wen", 32'(exp_wen), 32'(retire_wen));
      if (exp_wen) begin
        check("retire_rd", 32'(exp_rd), 32'(retire_rd));
        check("retire_data", exp_data, retire_data);
        xreg[exp_rd] = exp_data;
      end
      shadow_pc = shadow_pc + 32'd4; // Every retired instruction steps.
      check("pc", shadow_pc, pc);
    end
  endtask

  task automatic do_op_imm(input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] exp;
    exp = expect_alu(f3, 1'b0, xreg[rs1], {{20{imm[11]}}, imm});
    run_inst(enc_i(f3, rd, rs1, imm), rd != 5'd0, rd, exp);
  endtask

  task automatic do_op_reg(input logic [6:0] f7, input logic [2:0] f3,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] exp;
    exp = expect_alu(f3, f7 == F7_SUB, xreg[rs1], xreg[rs2]);
    run_inst(enc_r(f7, f3, rd, rs1, rs2), rd != 5'd0, rd, exp);
  endtask

  task automatic do_upper(input logic is_auipc, input logic [4:0] rd, input logic [19:0] imm);
    logic [31:0] exp;
    exp = is_auipc ? shadow_pc + {imm, 12'b0} : {imm, 12'b0};
    run_inst({imm, rd, is_auipc ? OPC_AUIPC : OPC_LUI}, rd != 5'd0, rd, exp);
  endtask

  // lui then an addi that reads it back to back.
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    do_upper(1'b0, rd, value[31:12] + {19'b0, value[11]});
    do_op_imm(F3_ADD, rd, rd, value[11:0]);
  endtask

  task automatic test_reset();
    check("pc", 32'h8000_0000, pc);
    check("next_pc", shadow_pc + 32'd4, next_pc);
    check("retire_valid", 32'd0, 32'(retire_valid));
    check("retire_wen", 32'd0, 32'(retire_wen));
    check("halted", 32'd0, 32'(halted));
    check("illegal_seen", 32'd0, 32'(illegal_seen));
  endtask

  task automatic test_op_imm();
    for (int i = 1; i <= 8; i++) begin
      rnd = $random(seed);
      load_reg(5'(i), rnd);
    end
    do_op_imm(F3_ADD, 5'd9, 5'd1, 12'h800); // Most negative immediate.
    do_op_imm(F3_AND, 5'd10, 5'd9, 12'hfff);
    do_op_imm(F3_SLT, 5'd11, 5'd10, 12'hffe);
    for (int k = 0; k < 20; k++) begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      do_op_imm(pick_f3(rnd2), rnd[4:0], rnd[9:5], rnd[21:10]);
    end
  endtask

  task automatic test_op_reg();
    logic [31:0] sel;
    load_reg(5'd12, 32'hffff_fffb); // -5.
    load_reg(5'd13, 32'd3);
    do_op_reg(7'd0, F3_SLT, 5'd14, 5'd12, 5'd13); // -5 < 3 gives 1.
    do_op_reg(7'd0, F3_SLT, 5'd15, 5'd13, 5'd12); // 3 < -5 gives 0.
    do_op_reg(F7_SUB, F3_ADD, 5'd16, 5'd13, 5'd12);
    for (int k = 0; k < 20; k++) begin
      rnd = $random(seed);
      sel = {24'b0, rnd[31:24]} % 32'd6;
      if (sel == 32'd5) begin
        do_op_reg(F7_SUB, F3_ADD, rnd[4:0], rnd[9:5], rnd[14:10]);
      end else begin
        do_op_reg(7'd0, pick_f3(sel), rnd[4:0], rnd[9:5], rnd[14:10]);
      end
    end
  endtask

  task automatic test_upper();
    rnd = $random(seed);
    do_upper(1'b0, 5'd17, rnd[19:0]);
    do_upper(1'b1, 5'd18, rnd[31:12]);
    do_upper(1'b1, 5'd19, 20'hfffff); // pc minus 4096.
    do_upper(1'b0, 5'd0, rnd[31:12]); // Retires with wen low.
    do_op_reg(7'd0, F3_OR, 5'd20, 5'd0, 5'd0);
    do_op_imm(F3_ADD, 5'd21, 5'd0, 12'h000);
  endtask

  task automatic test_gaps_illegal();
    for (int k = 0; k < 3; k++) begin
      rnd  = $random(seed);
      inst = rnd; // Ignored while inst_valid is low.
      @(negedge clk);
      check("retire_valid", 32'd0, 32'(retire_valid));
      check("pc", shadow_pc, pc);
    end
    check("illegal_seen", 32'd0, 32'(illegal_seen));
    run_inst(enc_r(7'd0, 3'b001, 5'd22, 5'd1, 5'd2), 1'b0, 5'd0, 32'd0); // sll.
    check("illegal_seen", 32'd1, 32'(illegal_seen));
    run_inst(32'h0000_0073, 1'b0, 5'd0, 32'd0); // ecall.
    check("halted", 32'd0, 32'(halted));
  endtask

  task automatic test_ebreak();
    run_inst(INST_EBREAK, 1'b0, 5'd0, 32'd0);
    check("halted", 32'd1, 32'(halted));
    for (int k = 0; k < 3; k++) begin
      inst_valid = 1'b1;
      inst       = enc_i(F3_ADD, 5'd1, 5'd0, 12'h7ff);
      @(negedge clk);
      inst_valid = 1'b0;
      check("retire_valid", 32'd0, 32'(retire_valid));
      check("pc", shadow_pc, pc); // Frozen while halted.
    end
    @(negedge clk);
    check("retire_valid", 32'd0, 32'(retire_valid));
    check("halted", 32'd1, 32'(halted));
  endtask

  initial begin
    seed       = 32'h9b20_7bc2;
    clk        = 1'b0;
    arst_n     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    shadow_pc  = 32'h8000_0000;
    for (int i = 0; i < 32; i++) begin
      xreg[i] = 32'd0;
    end
    repeat (4) @(negedge clk);
    arst_n = 1'b1; // Tests start on a falling edge.

    test_reset();
    test_op_imm();
    test_op_reg();
    test_upper();
    test_gaps_illegal();
    test_ebreak();

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
rv_pkg.sv
decode_if.sv
rv_decoder.sv
reg_file.sv
alu_exec.sv
retire_unit.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
SIM     := verilator
FLAGS   := --binary --timing --assert
TOP     := tb_core
FLIST   := flist.f
OBJ_DIR := obj_dir

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
